//--- logic/edit_mem_defines.svh
// edit memory sizes
`ifndef EDIT_MEM_DEFINES_SVH
`define EDIT_MEM_DEFINES_SVH

`default_nettype none

// ----------------------------------------------------------
// buffer geometry
// ----------------------------------------------------------
`define EM_BUF_PTR_NBITS 4 // 16 buffers
`define EM_BUF_PTR_LSB_NBITS 2 // 4 lines per buffer
`define EM_NUM_BUFS (1 << `EM_BUF_PTR_NBITS)

// ----------------------------------------------------------
// datapath and ports
// ----------------------------------------------------------
`define DATA_PATH_NBITS 32
`define PORT_ID_NBITS 2

// ----------------------------------------------------------
// packets and queues
// ----------------------------------------------------------
`define EM_MAX_PKT_LINES 12 // 3 buffers worst case
`define EM_LEN_NBITS $clog2(`EM_MAX_PKT_LINES + 1)
`define EM_DESC_DEPTH 4 // descriptors waiting for the walker
`define EM_DESC_PTR_NBITS $clog2(`EM_DESC_DEPTH)
`define EM_POOL_LOW_MARK 3 // below this many free buffers, hold off sop

`default_nettype wire

`endif

//--- logic/edit_mem_pkg.sv
// edit memory shared types
`include "edit_mem_defines.svh"
`default_nettype none

package edit_mem_pkg;

	// word from the processing unit
	typedef struct packed {
		logic valid;
		logic sop;
		logic eop;
		logic [`PORT_ID_NBITS-1:0] port;
		logic [`DATA_PATH_NBITS-1:0] data;
	} pu_word_t;

	typedef struct packed {
		logic valid;
		logic [`EM_BUF_PTR_NBITS-1:0] ptr;
		logic [`EM_BUF_PTR_LSB_NBITS-1:0] line;
		logic [`DATA_PATH_NBITS-1:0] data;
	} em_wr_t;

	// line request from the read walker
	typedef struct packed {
		logic valid;
		logic [`PORT_ID_NBITS-1:0] port;
		logic sop;
		logic eop;
		logic [`EM_BUF_PTR_NBITS-1:0] ptr;
		logic [`EM_BUF_PTR_LSB_NBITS-1:0] line;
	} em_req_t;

	typedef struct packed {
		logic [`EM_BUF_PTR_NBITS-1:0] head; // first buffer of the packet
		logic [`EM_LEN_NBITS-1:0] len; // lines, 1 based
		logic [`PORT_ID_NBITS-1:0] port;
	} em_desc_t;

	typedef struct packed {
		logic ack;
		logic [`PORT_ID_NBITS-1:0] port;
		logic sop;
		logic eop;
		logic [`DATA_PATH_NBITS-1:0] data;
	} em_out_t;

	typedef struct packed {
		logic valid;
		logic [`EM_BUF_PTR_NBITS-1:0] from_ptr;
		logic [`EM_BUF_PTR_NBITS-1:0] to_ptr; // next buffer of the same packet
	} em_link_wr_t;

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_LOAD, SEQ_STREAM} seq_state_e;

	typedef enum logic {POOL_INIT, POOL_RUN} pool_state_e;

endpackage

`default_nettype wire

//--- logic/ram_1r1w.sv
// one read one write ram
`default_nettype none

module ram_1r1w #(
	parameter int DATA_NBITS = 32,
	parameter int ADDR_NBITS = 6
) (
	input wire clk,
	input wire wr,
	input wire [ADDR_NBITS-1:0] waddr,
	input wire [ADDR_NBITS-1:0] raddr,
	input wire [DATA_NBITS-1:0] din,
	output logic [DATA_NBITS-1:0] dout
);

	logic [DATA_NBITS-1:0] mem [1 << ADDR_NBITS]; // no init, contents undefined until written

	// ----------------------------------------------------------
	// write port
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
	end

	// registered read, old data on a same-address collision
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- logic/edit_mem_pu_decode.sv
// processing unit write decode
`include "edit_mem_defines.svh"
`default_nettype none

module edit_mem_pu_decode
	import edit_mem_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire pu_word_t pu_in,
	input wire [`EM_BUF_PTR_NBITS-1:0] free_ptr, // head of the free pool
	output logic pool_pop,
	output em_wr_t wr,
	output em_link_wr_t link_wr,
	output logic desc_push,
	output em_desc_t desc
);

	logic [`EM_BUF_PTR_NBITS-1:0] cur_ptr; // buffer being filled
	logic [`EM_BUF_PTR_LSB_NBITS-1:0] line_cnt; // next free line in cur_ptr
	logic [`EM_BUF_PTR_NBITS-1:0] head_ptr;
	logic [`EM_LEN_NBITS-1:0] pkt_len; // lines so far
	logic [`PORT_ID_NBITS-1:0] pkt_port;
	logic need_buf;
	logic [`EM_BUF_PTR_NBITS-1:0] wr_ptr;
	logic [`EM_BUF_PTR_LSB_NBITS-1:0] wr_line;
	logic [`EM_LEN_NBITS-1:0] len_base;
	logic [`EM_LEN_NBITS-1:0] len_now;
	logic [`EM_BUF_PTR_NBITS-1:0] head_now;
	logic [`PORT_ID_NBITS-1:0] port_now;
	em_desc_t desc_d1;
	logic push_d1;

	// ----------------------------------------------------------
	// buffer assignment for the incoming word
	// ----------------------------------------------------------
	// line_cnt wraps to 0 after line 3, so 0 mid packet means buffer full
	assign need_buf = pu_in.valid & (pu_in.sop | (line_cnt == '0));
	assign pool_pop = need_buf;
	assign wr_ptr = need_buf ? free_ptr : cur_ptr;
	assign wr_line = pu_in.sop ? '0 : line_cnt; // sop always starts at line 0

	assign len_base = pu_in.sop ? '0 : pkt_len;
	assign len_now = len_base + 1'b1; // count including this word
	assign head_now = pu_in.sop ? free_ptr : head_ptr;
	assign port_now = pu_in.sop ? pu_in.port : pkt_port; // port taken from sop

	// ----------------------------------------------------------
	// registered outputs and packet state
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			line_cnt <= '0;
			wr.valid <= 1'b0;
			link_wr.valid <= 1'b0;
			push_d1 <= 1'b0;
			desc_push <= 1'b0;
		end else begin
			// memory write, one cycle behind the input
			wr.valid <= pu_in.valid;
			wr.ptr <= wr_ptr;
			wr.line <= wr_line;
			wr.data <= pu_in.data;

			// chain old buffer to the new one on a boundary crossing
			link_wr.valid <= need_buf & ~pu_in.sop;
			link_wr.from_ptr <= cur_ptr;
			link_wr.to_ptr <= free_ptr;

			// descriptor goes out two stages after eop
			push_d1 <= pu_in.valid & pu_in.eop;
			desc_d1.head <= head_now;
			desc_d1.len <= len_now;
			desc_d1.port <= port_now;
			desc_push <= push_d1;
			desc <= desc_d1;

			if (pu_in.valid) begin
				line_cnt <= wr_line + 1'b1;
				cur_ptr <= wr_ptr;
				head_ptr <= head_now;
				pkt_len <= len_now;
				pkt_port <= port_now;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/edit_mem_shared_memory.sv
// edit memory storage and readout
`include "edit_mem_defines.svh"
`default_nettype none

module edit_mem_shared_memory
	import edit_mem_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire em_wr_t wr,
	input wire em_req_t req,
	output logic rel_valid, // buffer free again
	output logic [`EM_BUF_PTR_NBITS-1:0] rel_ptr,
	output em_out_t out
);

	em_req_t req_d1; // request stage 1, ram address stage
	logic ack_d2;
	logic [`PORT_ID_NBITS-1:0] port_d2;
	logic sop_d2;
	logic eop_d2;
	logic [`DATA_PATH_NBITS-1:0] ram_dout;

	// ----------------------------------------------------------
	// request pipeline
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			req_d1.valid <= 1'b0;
			ack_d2 <= 1'b0;
			rel_valid <= 1'b0;
			out.ack <= 1'b0;
		end else begin
			req_d1 <= req;

			// attributes follow the ram read latency
			ack_d2 <= req_d1.valid;
			port_d2 <= req_d1.port;
			sop_d2 <= req_d1.sop;
			eop_d2 <= req_d1.eop;

			// last line of a buffer or eop frees it
			rel_valid <= req_d1.valid & ((&req_d1.line) | req_d1.eop);
			rel_ptr <= req_d1.ptr;

			out.ack <= ack_d2;
			out.port <= port_d2;
			out.sop <= sop_d2;
			out.eop <= eop_d2;
			out.data <= ram_dout;
		end
	end

	// ----------------------------------------------------------
	// line storage, address is {buffer, line}
	// ----------------------------------------------------------
	// write lands in the ram at the next edge after wr
	ram_1r1w #(
		.DATA_NBITS(`DATA_PATH_NBITS),
		.ADDR_NBITS(`EM_BUF_PTR_NBITS + `EM_BUF_PTR_LSB_NBITS)
	) u_ram_1r1w (
		.clk(clk),
		.wr(wr.valid),
		.waddr({wr.ptr, wr.line}),
		.raddr({req_d1.ptr, req_d1.line}),
		.din(wr.data),
		.dout(ram_dout)
	);

endmodule

`default_nettype wire

//--- logic/edit_mem_buf_pool.sv
// free buffer pool
`include "edit_mem_defines.svh"
`default_nettype none

module edit_mem_buf_pool
	import edit_mem_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire pop,
	output logic [`EM_BUF_PTR_NBITS-1:0] free_ptr, // valid while not empty
	input wire rel_valid,
	input wire [`EM_BUF_PTR_NBITS-1:0] rel_ptr,
	output logic pool_low
);

	pool_state_e state;
	logic [`EM_BUF_PTR_NBITS-1:0] fifo [`EM_NUM_BUFS];
	logic [`EM_BUF_PTR_NBITS-1:0] rd_ptr;
	logic [`EM_BUF_PTR_NBITS-1:0] wr_ptr;
	logic [`EM_BUF_PTR_NBITS-1:0] init_idx; // next index entered during init
	logic [`EM_BUF_PTR_NBITS:0] count; // 0..16
	logic push;
	logic [`EM_BUF_PTR_NBITS-1:0] push_ptr;

	// init fills every index, after that only releases push
	assign push = (state == POOL_INIT) | rel_valid;
	assign push_ptr = (state == POOL_INIT) ? init_idx : rel_ptr;
	assign free_ptr = fifo[rd_ptr];
	assign pool_low = (state == POOL_INIT) | (count < `EM_POOL_LOW_MARK);

	// ----------------------------------------------------------
	// storage
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (push) begin
			fifo[wr_ptr] <= push_ptr;
		end
	end

	// ----------------------------------------------------------
	// pointers, occupancy, init sweep
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= POOL_INIT;
			init_idx <= '0;
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1; // wraps at 16
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			count <= count + push - pop;
			if (state == POOL_INIT) begin
				init_idx <= init_idx + 1'b1;
				if (&init_idx) state <= POOL_RUN; // all 16 entered
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/edit_mem_read_seq.sv
// read sequencer
`include "edit_mem_defines.svh"
`default_nettype none

module edit_mem_read_seq
	import edit_mem_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire desc_push,
	input wire em_desc_t desc,
	input wire em_link_wr_t link_wr,
	input wire tx_pause, // holds the current line
	output em_req_t req
);

	seq_state_e state;
	em_desc_t q_mem [`EM_DESC_DEPTH];
	logic [`EM_DESC_PTR_NBITS-1:0] q_wr;
	logic [`EM_DESC_PTR_NBITS-1:0] q_rd;
	logic [`EM_DESC_PTR_NBITS:0] q_cnt;
	em_desc_t q_head;
	logic [`EM_BUF_PTR_NBITS-1:0] link_tbl [`EM_NUM_BUFS]; // next buffer per buffer
	logic [`EM_BUF_PTR_NBITS-1:0] cur_ptr;
	logic [`EM_BUF_PTR_LSB_NBITS-1:0] cur_line;
	logic [`EM_LEN_NBITS-1:0] left; // lines after the current one
	logic [`PORT_ID_NBITS-1:0] cur_port;
	logic q_empty;
	logic issue;
	logic last;
	logic load;

	// ----------------------------------------------------------
	// descriptor queue and link table
	// ----------------------------------------------------------
	assign q_empty = (q_cnt == '0);
	assign q_head = q_mem[q_rd];

	always_ff @(posedge clk) begin
		if (desc_push) q_mem[q_wr] <= desc;
		if (link_wr.valid) link_tbl[link_wr.from_ptr] <= link_wr.to_ptr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			q_wr <= '0;
			q_rd <= '0;
			q_cnt <= '0;
		end else begin
			if (desc_push) q_wr <= q_wr + 1'b1;
			if (load) q_rd <= q_rd + 1'b1;
			q_cnt <= q_cnt + desc_push - load;
		end
	end

	// ----------------------------------------------------------
	// walker
	// ----------------------------------------------------------
	assign issue = (state != SEQ_IDLE) & ~tx_pause;
	assign last = (left == '0);
	// next packet loads when idle or right behind the eop request
	assign load = ~q_empty & ((state == SEQ_IDLE) | (issue & last));

	assign req = '{valid: issue, port: cur_port, sop: (state == SEQ_LOAD),
		eop: last, ptr: cur_ptr, line: cur_line};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
		end else if (load) begin
			state <= SEQ_LOAD; // first line goes out next
		end else if (issue) begin
			state <= last ? SEQ_IDLE : SEQ_STREAM;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			cur_ptr <= q_head.head;
			cur_line <= '0;
			left <= q_head.len - 1'b1;
			cur_port <= q_head.port;
		end else if (issue) begin
			left <= left - 1'b1;
			cur_line <= cur_line + 1'b1; // wraps into the next buffer
			if (&cur_line) cur_ptr <= link_tbl[cur_ptr]; // follow the chain
		end
	end

endmodule

`default_nettype wire

//--- logic/edit_mem_top.sv
// edit memory subsystem
`include "edit_mem_defines.svh"
`default_nettype none

module edit_mem_top
	import edit_mem_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire pu_word_t pu_in,
	input wire tx_pause,
	output em_out_t out,
	output logic pool_low // source holds off new packets
);

	logic [`EM_BUF_PTR_NBITS-1:0] free_ptr;
	logic pool_pop;
	em_wr_t wr;
	em_link_wr_t link_wr;
	logic desc_push;
	em_desc_t desc;
	em_req_t req;
	logic rel_valid;
	logic [`EM_BUF_PTR_NBITS-1:0] rel_ptr;

	// ----------------------------------------------------------
	// write side
	// ----------------------------------------------------------
	edit_mem_pu_decode u_pu_decode (
		.clk(clk),
		.reset(reset),
		.pu_in(pu_in),
		.free_ptr(free_ptr),
		.pool_pop(pool_pop),
		.wr(wr),
		.link_wr(link_wr),
		.desc_push(desc_push),
		.desc(desc)
	);

	// storage, ram inside
	edit_mem_shared_memory u_shared_memory (
		.clk(clk),
		.reset(reset),
		.wr(wr),
		.req(req),
		.rel_valid(rel_valid),
		.rel_ptr(rel_ptr),
		.out(out)
	);

	edit_mem_buf_pool u_buf_pool (
		.clk(clk),
		.reset(reset),
		.pop(pool_pop),
		.free_ptr(free_ptr),
		.rel_valid(rel_valid),
		.rel_ptr(rel_ptr),
		.pool_low(pool_low)
	);

	// ----------------------------------------------------------
	// read side
	// ----------------------------------------------------------
	edit_mem_read_seq u_read_seq (
		.clk(clk),
		.reset(reset),
		.desc_push(desc_push),
		.desc(desc),
		.link_wr(link_wr),
		.tx_pause(tx_pause),
		.req(req)
	);

endmodule

`default_nettype wire

//--- sim/edit_mem_tb.sv
// edit memory testbench
`include "edit_mem_defines.svh"
`default_nettype none

module edit_mem_tb
	import edit_mem_pkg::*;
();

	localparam int CLK_HALF = 10; // 20 unit period
	localparam int RESET_CYCLES = 5;
	localparam int NUM_SINGLE = 12;
	localparam int NUM_MULTI = 12;
	localparam int NUM_MIXED = 16;
	localparam int NUM_PKTS = NUM_SINGLE + NUM_MULTI + NUM_MIXED;
	localparam int CYCLES_PER_PKT = 40;
	localparam int MAX_INFLIGHT = `EM_DESC_DEPTH; // descriptor queue never overflows

	logic clk;
	logic reset;
	pu_word_t pu_in;
	logic tx_pause;
	em_out_t out;
	logic pool_low;

	integer seed;
	integer pause_seed;
	string test_name;
	em_out_t expected_q [$]; // lines in output order
	int inflight; // packets started, eop not yet out
	int pause_left;
	logic pause_on;
	logic [2:0] pause_hist; // tx_pause at the last three negedges, newest in bit 0

	edit_mem_top DUT (
		.clk(clk),
		.reset(reset),
		.pu_in(pu_in),
		.tx_pause(tx_pause),
		.out(out),
		.pool_low(pool_low)
	);

	initial clk = 1'b0;
	always #CLK_HALF clk = ~clk;

	// ----------------------------------------------------------
	// reference model and reporting
	// ----------------------------------------------------------
	// expected line for word idx of a len line packet
	function automatic em_out_t expected_line(input logic [`PORT_ID_NBITS-1:0] port,
		input int idx, input int len, input logic [`DATA_PATH_NBITS-1:0] data);
		em_out_t exp_line;
		exp_line.ack = 1'b1;
		exp_line.port = port; // whole packet on the sop port
		exp_line.sop = (idx == 0);
		exp_line.eop = (idx == len - 1);
		exp_line.data = data;
		return exp_line;
	endfunction

	task automatic stop_failed();
		$display("Regression failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		stop_failed();
	endtask

	task automatic check_value(input string field, input logic [`DATA_PATH_NBITS-1:0] expected,
		input logic [`DATA_PATH_NBITS-1:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
			stop_failed();
		end
	endtask

	// ----------------------------------------------------------
	// stimulus helpers, all entered at edge + 2
	// ----------------------------------------------------------
	task automatic wait_for_room();
		while (pool_low || inflight >= MAX_INFLIGHT) begin // source obeys pool_low
			pu_in.valid = 1'b0;
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_packet(input int len, input bit gaps);
		logic [`PORT_ID_NBITS-1:0] port;
		logic [`DATA_PATH_NBITS-1:0] data;
		int i;
		port = `PORT_ID_NBITS'($random(seed));
		wait_for_room();
		inflight++;
		for (i = 0; i < len; i++) begin
			// idle cycles inside the packet
			while (gaps && i > 0 && ($unsigned($random(seed)) % 4) == 0) begin
				pu_in.valid = 1'b0;
				@(posedge clk);
				#2;
			end
			data = $random(seed);
			pu_in = '{valid: 1'b1, sop: (i == 0), eop: (i == len - 1), port: port, data: data};
			expected_q.push_back(expected_line(port, i, len, data));
			@(posedge clk);
			#2;
		end
		pu_in = '0;
	endtask

	task automatic wait_drain();
		while (expected_q.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk); // let the last release reach the pool
		#2;
	endtask

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial begin
		seed = 32'ha1c9_ae7e;
		pause_seed = 32'ha1c9_ae7e;
		pu_in = '0;
		tx_pause = 1'b0;
		pause_on = 1'b0;
		pause_hist = '0;
		reset = 1'b1;
		inflight = 0;
		pause_left = 0;
		test_name = "reset";
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;
		check_value("ack", 0, out.ack);
		check_value("pool_low during init", 1, pool_low); // fill takes 16 cycles

		test_name = "single_line";
		repeat (NUM_SINGLE) send_packet(1, 1'b0);
		wait_drain();

		test_name = "multi_buffer"; // 5 to 12 lines, up to 3 linked buffers
		repeat (NUM_MULTI) send_packet(5 + $unsigned($random(seed)) % 8, 1'b0);
		wait_drain();

		test_name = "tx_pause";
		pause_on = 1'b1;
		repeat (NUM_MIXED) send_packet(1 + $unsigned($random(seed)) % 12, 1'b1);
		pause_on = 1'b0;
		wait_drain();

		test_name = "final";
		check_value("pool_low after drain", 0, pool_low);
		$display("Regression passed");
		$finish;
	end

	// random pause spans, only in the pause test
	always begin : pause_driver
		@(posedge clk);
		#2;
		if (!pause_on) begin
			tx_pause = 1'b0;
			pause_left = 0;
		end else if (pause_left > 0) begin
			pause_left--;
		end else begin
			tx_pause = ~tx_pause;
			if (tx_pause) pause_left = $unsigned($random(pause_seed)) % 8;
			else pause_left = $unsigned($random(pause_seed)) % 16;
		end
	end

	// ----------------------------------------------------------
	// compare, sampled mid cycle
	// ----------------------------------------------------------
	always @(negedge clk) begin : compare_out
		em_out_t exp_line;
		// a paused cycle issues no request, so no line three edges later
		if (!reset && pause_hist[2]) check_value("ack under tx_pause", 0, out.ack);
		if (!reset && out.ack) begin
			if (expected_q.size() == 0) begin
				abort_run("output line arrived while no input line was pending");
			end else begin
				exp_line = expected_q.pop_front();
				check_value("port", exp_line.port, out.port);
				check_value("sop", exp_line.sop, out.sop);
				check_value("eop", exp_line.eop, out.eop);
				check_value("data", exp_line.data, out.data);
				if (exp_line.eop) inflight--; // packet complete
			end
		end
		pause_hist = {pause_hist[1:0], tx_pause};
	end

	initial begin : watchdog
		repeat (NUM_PKTS * CYCLES_PER_PKT + RESET_CYCLES + 2 * `EM_NUM_BUFS) @(posedge clk);
		abort_run("timeout, the traffic did not drain in time");
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/edit_mem_pkg.sv
logic/ram_1r1w.sv
logic/edit_mem_pu_decode.sv
logic/edit_mem_shared_memory.sv
logic/edit_mem_buf_pool.sv
logic/edit_mem_read_seq.sv
logic/edit_mem_top.sv
sim/edit_mem_tb.sv

//--- Makefile
# Verilator flow for the edit memory subsystem

TB_TOP = edit_mem_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module edit_mem_top

# the log decides pass or fail, the binary exit code does not
sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
